//--- hw/serializer_pkg.sv
package serializer_pkg;

   // task type, 0 to 2 are real types
   typedef logic [1:0] task_type_t;

   // request-only wildcard that matches any real type
   localparam task_type_t TASK_TYPE_ALL = 2'd3;

   // conflict hint, top bit flags a read-only task
   typedef logic [15:0] hint_t;
   localparam int HINT_RO_BIT = 15;

   typedef logic [15:0] timestamp_t;

   typedef struct packed {
      task_type_t ttype;
      hint_t      hint;
      timestamp_t ts;
   } task_t;

   // task queue slot that travels with the task
   typedef logic [3:0] cq_slot_t;

   typedef struct packed {
      task_t    tsk;
      cq_slot_t slot;
      logic     valid;
      logic     conflict;
   } ready_entry_t;

   // sized for the largest core count and list depth (16 each)
   localparam int CORE_ID_W   = 4;
   localparam int ENTRY_IDX_W = 4;

   typedef logic [CORE_ID_W-1:0]   core_id_t;
   typedef logic [ENTRY_IDX_W-1:0] entry_idx_t;

   // registered dispatch decision
   typedef struct packed {
      logic       valid;
      core_id_t   core;
      entry_idx_t index;
   } grant_t;

endpackage

//--- hw/lowbit.sv
`timescale 1ns/1ps

module lowbit #(
   parameter int IN_WIDTH  = 8,
   parameter int OUT_WIDTH = 3
) (
   input  logic [IN_WIDTH-1:0]  in,
   output logic [OUT_WIDTH-1:0] out,
   output logic                 found
);

   // scan from the top so the lowest set bit is written last
   always_comb begin
      out = '0;
      for (int i = IN_WIDTH - 1; i >= 0; i--) begin
         if (in[i]) begin
            out = OUT_WIDTH'(i);
         end
      end
   end

   assign found = |in;

   always_comb begin
      if (found) begin
         assert (in[out])
            else $error("lowbit: index %0d does not select a set bit", out);
      end
   end

endmodule

//--- hw/running_hint_table.sv
`timescale 1ns/1ps

module running_hint_table #(
   parameter int NUM_CORES = 4
) (
   input  logic                     clk,
   input  logic                     rstn,
   input  serializer_pkg::grant_t   grant,
   input  serializer_pkg::hint_t    grant_hint,
   input  logic                     fin_valid,
   input  serializer_pkg::core_id_t fin_core,
   input  serializer_pkg::hint_t    enq_hint,
   output logic                     enq_conflict,
   output serializer_pkg::hint_t    fin_hint,
   output logic                     fin_hint_valid,
   output logic                     all_cores_idle
);

   serializer_pkg::hint_t [NUM_CORES-1:0] run_hint;
   logic [NUM_CORES-1:0]                  run_valid;
   logic [NUM_CORES-1:0]                  grant_sel;
   logic [NUM_CORES-1:0]                  fin_sel;
   logic [NUM_CORES-1:0]                  run_match;
   serializer_pkg::hint_t                 enq_hint_rw;

   // one-hot views of the granted and the finishing core
   always_comb begin
      for (int i = 0; i < NUM_CORES; i++) begin
         grant_sel[i] = grant.valid && (grant.core == serializer_pkg::core_id_t'(i));
         fin_sel[i]   = fin_valid && (fin_core == serializer_pkg::core_id_t'(i));
      end
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         run_valid <= '0;
      end else begin
         for (int i = 0; i < NUM_CORES; i++) begin
            if (grant_sel[i]) begin
               run_valid[i] <= 1'b1;
            end else if (fin_sel[i]) begin
               run_valid[i] <= 1'b0;
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      for (int i = 0; i < NUM_CORES; i++) begin
         if (grant_sel[i]) begin
            run_hint[i] <= grant_hint;
         end
      end
   end

   // read-only flag is not part of the comparison
   always_comb begin
      enq_hint_rw = enq_hint;
      enq_hint_rw[serializer_pkg::HINT_RO_BIT] = 1'b0;
   end

   // a core finishing right now no longer blocks the new task
   always_comb begin
      fin_hint = '0;
      for (int i = 0; i < NUM_CORES; i++) begin
         run_match[i] = run_valid[i] && (run_hint[i] == enq_hint_rw) && !fin_sel[i];
         if (fin_sel[i]) begin
            fin_hint = run_hint[i];
         end
      end
   end

   assign enq_conflict   = |run_match;
   assign fin_hint_valid = |(fin_sel & run_valid);
   assign all_cores_idle = (run_valid == '0);

   // a finish always refers to a core holding a task handed out earlier
   a_fin_running : assert property (@(posedge clk) disable iff (!rstn)
      fin_valid |-> (fin_sel & run_valid) != '0);

endmodule

//--- hw/ready_list.sv
`timescale 1ns/1ps

module ready_list #(
   parameter int LIST_DEPTH        = 8,
   parameter int ALMOST_FULL_LEVEL = 6
) (
   input  logic                                          clk,
   input  logic                                          rstn,
   input  logic                                          m_valid,
   input  serializer_pkg::task_t                         m_task,
   input  serializer_pkg::cq_slot_t                      m_slot,
   output logic                                          m_ready,
   input  logic                                          enq_conflict,
   input  serializer_pkg::hint_t                         fin_hint,
   input  logic                                          fin_hint_valid,
   input  serializer_pkg::grant_t                        grant,
   output serializer_pkg::ready_entry_t [LIST_DEPTH-1:0] entries,
   output serializer_pkg::task_t                         granted_task,
   output serializer_pkg::cq_slot_t                      granted_slot,
   output logic                                          almost_full
);

   localparam int IDX_W = $clog2(LIST_DEPTH);
   localparam logic [IDX_W:0] AF_LEVEL = ALMOST_FULL_LEVEL[IDX_W:0];

   serializer_pkg::ready_entry_t [LIST_DEPTH-1:0] list_q;
   serializer_pkg::ready_entry_t [LIST_DEPTH-1:0] list_d;
   serializer_pkg::ready_entry_t                  new_entry;
   serializer_pkg::task_t                         enq_task;
   logic [LIST_DEPTH-1:0]                         free_vec;
   logic [LIST_DEPTH-1:0]                         list_match;
   logic [LIST_DEPTH-1:0]                         clr_vec;
   logic [IDX_W-1:0]                              ins_idx;
   logic [IDX_W-1:0]                              clr_idx;
   logic [IDX_W-1:0]                              rem_idx;
   logic [IDX_W-1:0]                              push_idx;
   logic                                          ins_found;
   logic                                          clr_found;
   logic                                          push;
   logic                                          rem;
   logic [IDX_W:0]                                count_q;

   // incoming task with the read-only flag dropped
   always_comb begin
      enq_task = m_task;
      enq_task.hint[serializer_pkg::HINT_RO_BIT] = 1'b0;
   end

   always_comb begin
      for (int i = 0; i < LIST_DEPTH; i++) begin
         free_vec[i]   = !list_q[i].valid;
         list_match[i] = list_q[i].valid && (list_q[i].tsk.hint == enq_task.hint);
         clr_vec[i]    = fin_hint_valid && list_q[i].valid &&
                         (list_q[i].tsk.hint == fin_hint);
      end
   end

   always_comb begin
      new_entry.tsk      = enq_task;
      new_entry.slot     = m_slot;
      new_entry.valid    = 1'b1;
      new_entry.conflict = enq_conflict || (list_match != '0);
   end

   // lowest free entry, which is also the current occupancy
   lowbit #(
      .IN_WIDTH  (LIST_DEPTH),
      .OUT_WIDTH (IDX_W)
   ) ins_sel_i (
      .in    (free_vec),
      .out   (ins_idx),
      .found (ins_found)
   );

   // earliest waiting task with the finishing hint
   lowbit #(
      .IN_WIDTH  (LIST_DEPTH),
      .OUT_WIDTH (IDX_W)
   ) clr_sel_i (
      .in    (clr_vec),
      .out   (clr_idx),
      .found (clr_found)
   );

   assign m_ready  = m_valid && ins_found;
   assign push     = m_valid && m_ready;
   assign rem      = grant.valid;
   assign rem_idx  = grant.index[IDX_W-1:0];
   assign push_idx = rem ? ins_idx - 1'b1 : ins_idx;

   // conflict clear first, then the removal shift, then the insert
   always_comb begin
      list_d = list_q;
      if (clr_found) begin
         list_d[clr_idx].conflict = 1'b0;
      end
      if (rem) begin
         for (int i = 0; i < LIST_DEPTH - 1; i++) begin
            if (i >= int'(rem_idx)) begin
               list_d[i] = list_d[i+1];
            end
         end
         list_d[LIST_DEPTH-1].valid    = 1'b0;
         list_d[LIST_DEPTH-1].conflict = 1'b0;
      end
      if (push) begin
         list_d[push_idx] = new_entry;
      end
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         for (int i = 0; i < LIST_DEPTH; i++) begin
            list_q[i].valid    <= 1'b0;
            list_q[i].conflict <= 1'b0;
         end
      end else begin
         list_q <= list_d;
      end
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         count_q <= '0;
      end else begin
         case ({push, rem})
            2'b10:   count_q <= count_q + 1'b1;
            2'b01:   count_q <= count_q - 1'b1;
            default: count_q <= count_q;
         endcase
      end
   end

   assign almost_full  = (count_q >= AF_LEVEL);
   assign entries      = list_q;
   assign granted_task = list_q[rem_idx].tsk;
   assign granted_slot = list_q[rem_idx].slot;

   // the counter and the valid bits must move together through inserts and removals
   a_count_matches : assert property (@(posedge clk) disable iff (!rstn)
      count_q == $countones(~free_vec));

endmodule

//--- hw/dispatch_arbiter.sv
`timescale 1ns/1ps

module dispatch_arbiter #(
   parameter int NUM_CORES  = 4,
   parameter int LIST_DEPTH = 8
) (
   input  logic                                          clk,
   input  logic                                          rstn,
   input  logic [NUM_CORES-1:0]                          s_req,
   input  serializer_pkg::task_type_t [NUM_CORES-1:0]    s_req_type,
   input  serializer_pkg::ready_entry_t [LIST_DEPTH-1:0] entries,
   output serializer_pkg::grant_t                        grant,
   output logic [NUM_CORES-1:0]                          s_grant
);

   localparam int CORE_W  = $clog2(NUM_CORES);
   localparam int IDX_W   = $clog2(LIST_DEPTH);
   localparam int N_TYPES = 2 ** $bits(serializer_pkg::task_type_t);

   logic [N_TYPES-1:0][LIST_DEPTH-1:0] type_ready;
   logic [LIST_DEPTH-1:0]              pend_ok;
   logic [NUM_CORES-1:0]               can_take;
   logic [LIST_DEPTH-1:0]              core_ready;
   logic [CORE_W-1:0]                  core_sel;
   logic [IDX_W-1:0]                   entry_sel;
   logic [IDX_W-1:0]                   last_idx;
   logic                               core_found;
   logic                               entry_found;

   assign last_idx = grant.index[IDX_W-1:0];

   // ready vectors per request type, skipping the entry that leaves this cycle
   always_comb begin
      for (int j = 0; j < LIST_DEPTH; j++) begin
         pend_ok[j] = entries[j].valid && !entries[j].conflict &&
                      !(grant.valid && (last_idx == IDX_W'(j)));
      end
      for (int t = 0; t < N_TYPES; t++) begin
         for (int j = 0; j < LIST_DEPTH; j++) begin
            if (t == int'(serializer_pkg::TASK_TYPE_ALL)) begin
               type_ready[t][j] = pend_ok[j] &&
                                  (entries[j].tsk.ttype < serializer_pkg::TASK_TYPE_ALL);
            end else begin
               type_ready[t][j] = pend_ok[j] &&
                                  (entries[j].tsk.ttype == serializer_pkg::task_type_t'(t));
            end
         end
      end
   end

   // no back to back grants to one core
   always_comb begin
      for (int i = 0; i < NUM_CORES; i++) begin
         can_take[i] = s_req[i] && (type_ready[s_req_type[i]] != '0) &&
                       !(grant.valid && (grant.core == serializer_pkg::core_id_t'(i)));
      end
   end

   lowbit #(
      .IN_WIDTH  (NUM_CORES),
      .OUT_WIDTH (CORE_W)
   ) core_sel_i (
      .in    (can_take),
      .out   (core_sel),
      .found (core_found)
   );

   assign core_ready = type_ready[s_req_type[core_sel]];

   lowbit #(
      .IN_WIDTH  (LIST_DEPTH),
      .OUT_WIDTH (IDX_W)
   ) entry_sel_i (
      .in    (core_ready),
      .out   (entry_sel),
      .found (entry_found)
   );

   always_ff @(posedge clk) begin
      if (!rstn) begin
         grant.valid <= 1'b0;
      end else begin
         grant.valid <= core_found && entry_found;
         grant.core  <= serializer_pkg::core_id_t'(core_sel);
         // previous grant is removed at this edge, so later entries move down one
         if (grant.valid && (entry_sel > last_idx)) begin
            grant.index <= serializer_pkg::entry_idx_t'(entry_sel - 1'b1);
         end else begin
            grant.index <= serializer_pkg::entry_idx_t'(entry_sel);
         end
      end
   end

   always_comb begin
      for (int i = 0; i < NUM_CORES; i++) begin
         s_grant[i] = grant.valid && (grant.core == serializer_pkg::core_id_t'(i));
      end
   end

   // after the shift the registered index still lands on a waiting, conflict-free entry
   a_grant_entry : assert property (@(posedge clk) disable iff (!rstn)
      grant.valid |-> entries[last_idx].valid && !entries[last_idx].conflict);

endmodule

//--- hw/conflict_serializer.sv
`timescale 1ns/1ps

module conflict_serializer #(
   parameter int NUM_CORES         = 4,
   parameter int LIST_DEPTH        = 8,
   parameter int ALMOST_FULL_LEVEL = 6
) (
   input  logic                                       clk,
   input  logic                                       rstn,
   // enqueue side
   input  logic                                       m_valid,
   input  serializer_pkg::task_t                      m_task,
   input  serializer_pkg::cq_slot_t                   m_slot,
   output logic                                       m_ready,
   // core side
   input  logic [NUM_CORES-1:0]                       s_req,
   input  serializer_pkg::task_type_t [NUM_CORES-1:0] s_req_type,
   output logic [NUM_CORES-1:0]                       s_grant,
   output serializer_pkg::task_t                      s_task,
   output serializer_pkg::cq_slot_t                   s_slot,
   // finish side
   input  logic                                       fin_valid,
   input  serializer_pkg::core_id_t                   fin_core,
   // status
   output logic                                       almost_full,
   output logic                                       all_cores_idle
);

   serializer_pkg::ready_entry_t [LIST_DEPTH-1:0] entries;
   serializer_pkg::grant_t                        grant;
   serializer_pkg::hint_t                         fin_hint;
   logic                                          fin_hint_valid;
   logic                                          enq_conflict;

   // what runs on each core now
   running_hint_table #(
      .NUM_CORES (NUM_CORES)
   ) hint_table_i (
      .clk            (clk),
      .rstn           (rstn),
      .grant          (grant),
      .grant_hint     (s_task.hint),
      .fin_valid      (fin_valid),
      .fin_core       (fin_core),
      .enq_hint       (m_task.hint),
      .enq_conflict   (enq_conflict),
      .fin_hint       (fin_hint),
      .fin_hint_valid (fin_hint_valid),
      .all_cores_idle (all_cores_idle)
   );

   // what is waiting, oldest first
   ready_list #(
      .LIST_DEPTH        (LIST_DEPTH),
      .ALMOST_FULL_LEVEL (ALMOST_FULL_LEVEL)
   ) ready_list_i (
      .clk            (clk),
      .rstn           (rstn),
      .m_valid        (m_valid),
      .m_task         (m_task),
      .m_slot         (m_slot),
      .m_ready        (m_ready),
      .enq_conflict   (enq_conflict),
      .fin_hint       (fin_hint),
      .fin_hint_valid (fin_hint_valid),
      .grant          (grant),
      .entries        (entries),
      .granted_task   (s_task),
      .granted_slot   (s_slot),
      .almost_full    (almost_full)
   );

   dispatch_arbiter #(
      .NUM_CORES  (NUM_CORES),
      .LIST_DEPTH (LIST_DEPTH)
   ) arbiter_i (
      .clk        (clk),
      .rstn       (rstn),
      .s_req      (s_req),
      .s_req_type (s_req_type),
      .entries    (entries),
      .grant      (grant),
      .s_grant    (s_grant)
   );

endmodule

//--- sim/serializer_tb.sv
`timescale 1ns/1ps

module serializer_tb;

   localparam int CLK_PERIOD      = 20;
   localparam int NUM_CORES       = 4;
   localparam int CYCLES_PER_LINE = 200;
   localparam int GRANT_WAIT      = 50;

   logic                                       clk;
   logic                                       rstn;
   logic                                       m_valid;
   serializer_pkg::task_t                      m_task;
   serializer_pkg::cq_slot_t                   m_slot;
   logic                                       m_ready;
   logic [NUM_CORES-1:0]                       s_req;
   serializer_pkg::task_type_t [NUM_CORES-1:0] s_req_type;
   logic [NUM_CORES-1:0]                       s_grant;
   serializer_pkg::task_t                      s_task;
   serializer_pkg::cq_slot_t                   s_slot;
   logic                                       fin_valid;
   serializer_pkg::core_id_t                   fin_core;
   logic                                       almost_full;
   logic                                       all_cores_idle;

   string vec_q[$];
   int    n_ops;
   string cur_test;
   int    test_errs;
   int    tests_passed;
   int    tests_failed;

   conflict_serializer dut_i (
      .clk            (clk),
      .rstn           (rstn),
      .m_valid        (m_valid),
      .m_task         (m_task),
      .m_slot         (m_slot),
      .m_ready        (m_ready),
      .s_req          (s_req),
      .s_req_type     (s_req_type),
      .s_grant        (s_grant),
      .s_task         (s_task),
      .s_slot         (s_slot),
      .fin_valid      (fin_valid),
      .fin_core       (fin_core),
      .almost_full    (almost_full),
      .all_cores_idle (all_cores_idle)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   task automatic check_task(input string name, input serializer_pkg::task_t exp,
                             input serializer_pkg::task_t act);
      if (act !== exp) begin
         $display(
            "Error: test %s task expected type %0d hint %h ts %h, actual type %0d hint %h ts %h",
            name, exp.ttype, exp.hint, exp.ts, act.ttype, act.hint, act.ts);
         test_errs++;
      end
   endtask

   task automatic check_slot(input string name, input serializer_pkg::cq_slot_t exp,
                             input serializer_pkg::cq_slot_t act);
      if (act !== exp) begin
         $display("Error: test %s slot expected %h actual %h", name, exp, act);
         test_errs++;
      end
   endtask

   task automatic check_flag(input string name, input string what, input logic exp,
                             input logic act);
      if (act !== exp) begin
         $display("Error: test %s %s expected %b actual %b", name, what, exp, act);
         test_errs++;
      end
   endtask

   // report the test that just ended
   task automatic close_test();
      if (cur_test.len() > 0) begin
         if (test_errs == 0) begin
            $display("test %s passed", cur_test);
            tests_passed++;
         end else begin
            $display("test %s failed with %0d errors", cur_test, test_errs);
            tests_failed++;
         end
      end
      test_errs = 0;
   endtask

   task automatic read_vectors();
      int    fd;
      string line;
      fd = $fopen("sim/serializer_vectors.txt", "r");
      if (fd == 0) begin
         $display("could not open the vectors file sim/serializer_vectors.txt");
      end else begin
         while (!$feof(fd)) begin
            line = "";
            if ($fgets(line, fd) > 0) begin
               if (line.len() > 1 && line.substr(0, 0) != "#") begin
                  vec_q.push_back(line);
               end
            end
         end
         $fclose(fd);
      end
   endtask

   // every operation starts and ends just after a falling edge
   task automatic run_op(input string line);
      string       op;
      string       name;
      string       which;
      logic [31:0] a0;
      logic [31:0] a1;
      logic [31:0] a2;
      logic [31:0] a3;
      logic [31:0] a4;
      int          n;
      int          waited;
      serializer_pkg::task_t exp_task;
      n = $sscanf(line, "%s %s", op, name);
      if (name != cur_test) begin
         close_test();
         cur_test = name;
      end
      case (op)
         "E": begin
            n = $sscanf(line, "%s %s %h %h %h %h %h", op, name, a0, a1, a2, a3, a4);
            m_valid      = 1'b1;
            m_task.ttype = a0[1:0];
            m_task.hint  = a1[15:0];
            m_task.ts    = a2[15:0];
            m_slot       = a3[3:0];
            #(CLK_PERIOD / 4);
            check_flag(name, "m_ready", a4[0], m_ready);
            @(negedge clk);
            m_valid = 1'b0;
         end
         "R": begin
            n = $sscanf(line, "%s %s %h %h", op, name, a0, a1);
            s_req[a0[1:0]]      = 1'b1;
            s_req_type[a0[1:0]] = a1[1:0];
         end
         "G": begin
            n = $sscanf(line, "%s %s %h %h %h %h %h", op, name, a0, a1, a2, a3, a4);
            exp_task.ttype = a1[1:0];
            exp_task.hint  = a2[15:0];
            exp_task.ts    = a3[15:0];
            waited = 0;
            while (!s_grant[a0[1:0]] && waited < GRANT_WAIT) begin
               @(negedge clk);
               waited++;
            end
            if (s_grant[a0[1:0]]) begin
               check_task(name, exp_task, s_task);
               check_slot(name, a4[3:0], s_slot);
               // request is still up at the next edge, the same core must not win again
               @(negedge clk);
               check_flag(name, "s_grant", 1'b0, s_grant[a0[1:0]]);
            end else begin
               $display("test %s: core %0d got no grant within %0d cycles",
                        name, a0, GRANT_WAIT);
               test_errs++;
            end
            // the core has taken its task and drops the request
            s_req[a0[1:0]] = 1'b0;
         end
         "N": begin
            n = $sscanf(line, "%s %s %h %d", op, name, a0, a1);
            repeat (a1) begin
               @(negedge clk);
               check_flag(name, "s_grant", 1'b0, s_grant[a0[1:0]]);
            end
         end
         "X": begin
            n = $sscanf(line, "%s %s %h", op, name, a0);
            fin_valid = 1'b1;
            fin_core  = a0[3:0];
            @(negedge clk);
            fin_valid = 1'b0;
         end
         "I": begin
            n = $sscanf(line, "%s %s %d", op, name, a0);
            repeat (int'(a0) + int'($urandom_range(2, 0))) @(negedge clk);
         end
         "F": begin
            n = $sscanf(line, "%s %s %s %h", op, name, which, a0);
            case (which)
               "idle":        check_flag(name, which, a0[0], all_cores_idle);
               "almost_full": check_flag(name, which, a0[0], almost_full);
               "m_ready":     check_flag(name, which, a0[0], m_ready);
               default: begin
                  $display("test %s: unknown status flag %s", name, which);
                  test_errs++;
               end
            endcase
         end
         default: begin
            $display("test %s: unknown operation %s in the vectors file", name, op);
            test_errs++;
         end
      endcase
   endtask

   // limit grows with the number of vector lines
   initial begin
      wait (n_ops > 0);
      #(n_ops * CYCLES_PER_LINE * CLK_PERIOD);
      $display("watchdog expired after %0d cycles, the run is stuck", n_ops * CYCLES_PER_LINE);
      $display("Verification failed");
      $finish;
   end

   initial begin
      void'($urandom(32'h6c6a));
      rstn         = 1'b0;
      m_valid      = 1'b0;
      m_task       = '0;
      m_slot       = '0;
      s_req        = '0;
      s_req_type   = '0;
      fin_valid    = 1'b0;
      fin_core     = '0;
      cur_test     = "";
      test_errs    = 0;
      tests_passed = 0;
      tests_failed = 0;
      n_ops        = 0;
      read_vectors();
      n_ops = vec_q.size();
      repeat (10) @(negedge clk);
      rstn = 1'b1;
      foreach (vec_q[i]) begin
         run_op(vec_q[i]);
      end
      close_test();
      $display("tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
      if (tests_failed == 0 && tests_passed > 0) begin
         $display("Verification passed");
      end else begin
         $display("Verification failed");
      end
      $finish;
   end

endmodule

//--- sim/serializer_vectors.txt
# op test args, hex: E type hint ts slot ready | R core type | G core type hint ts slot
# N core cycles(dec) | X core | I cycles(dec) | F flag(idle, almost_full, m_ready) value
F reset idle 1
F reset almost_full 0
N reset 0 2
E basic 0 8123 0010 1 1
R basic 0 0
G basic 0 0 0123 0010 1
F basic idle 0
X basic 0
F basic idle 1
I basic 2
E serialize 1 0042 0020 2 1
E serialize 1 8042 0021 3 1
R serialize 0 1
G serialize 0 1 0042 0020 2
F serialize idle 0
R serialize 1 1
N serialize 1 4
X serialize 0
G serialize 1 1 0042 0021 3
X serialize 1
F serialize idle 1
E typematch 0 0100 0030 4 1
E typematch 1 0200 0031 5 1
E typematch 2 0300 0032 6 1
R typematch 2 1
G typematch 2 1 0200 0031 5
R typematch 3 3
G typematch 3 0 0100 0030 4
R typematch 0 3
G typematch 0 2 0300 0032 6
X typematch 2
X typematch 3
X typematch 0
F typematch idle 1
E arbitrate 0 0500 0040 7 1
E arbitrate 0 0600 0041 8 1
R arbitrate 2 0
R arbitrate 1 0
G arbitrate 1 0 0500 0040 7
G arbitrate 2 0 0600 0041 8
X arbitrate 1
X arbitrate 2
I arbitrate 2
E occupancy 0 0a01 0050 0 1
E occupancy 0 0a02 0051 1 1
E occupancy 0 0a03 0052 2 1
E occupancy 0 0a04 0053 3 1
E occupancy 0 0a05 0054 4 1
F occupancy almost_full 0
E occupancy 0 0a06 0055 5 1
F occupancy almost_full 1
E occupancy 0 0a07 0056 6 1
E occupancy 0 0a08 0057 7 1
E occupancy 0 0a09 0058 8 0
R occupancy 0 0
G occupancy 0 0 0a01 0050 0
E occupancy 0 0a09 0058 8 1
F occupancy almost_full 1

//--- project.f
hw/serializer_pkg.sv
hw/lowbit.sv
hw/running_hint_table.sv
hw/ready_list.sv
hw/dispatch_arbiter.sv
hw/conflict_serializer.sv
sim/serializer_tb.sv

//--- run_sim.sh
#!/bin/sh
# build the testbench with Verilator, run it and judge the result from the log

cd "$(dirname "$0")" || exit 1

LOG=sim_run.log

verilator --binary --timing --assert -Wno-fatal \
   -f project.f --top-module serializer_tb -o serializer_sim
status=$?
if [ $status -ne 0 ]; then
   echo "verilator build failed with status $status"
   exit 1
fi

./obj_dir/serializer_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "Verification failed" "$LOG"; then
   exit 1
fi
if ! grep -q "Verification passed" "$LOG"; then
   echo "simulation ended without a result line"
   exit 1
fi
exit 0
